/* hw/lb_cfg.svh */
// Line buffer sizes
`ifndef LB_CFG_SVH
`define LB_CFG_SVH

// bits per RGB pixel
`define LB_PIXEL_BITS 24

// image geometry
`define LB_IMG_WIDTH  16
`define LB_IMG_HEIGHT 8

// four rows for the window plus one spare row being written
`define LB_NUM_BANKS  5

// window edge in pixels
`define LB_WIN_SIZE   4

`endif

/* hw/lb_pixel_pkg.sv */
// Pixel data types
`default_nettype none

`include "lb_cfg.svh"

package lb_pixel_pkg;

    //////////////////////////////////////////////////////////////////////
    // payload types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`LB_PIXEL_BITS-1:0] pixel_t;    // packed RGB

    typedef pixel_t [`LB_WIN_SIZE-1:0] column_t;   // index 0 is the oldest row

    typedef column_t [`LB_WIN_SIZE-1:0] window_t;  // index 0 is the leftmost column

endpackage

`default_nettype wire

/* hw/lb_ctrl_pkg.sv */
// Line buffer control types
`default_nettype none

`include "lb_cfg.svh"

package lb_ctrl_pkg;

    localparam int BANK_BITS = $clog2(`LB_NUM_BANKS);

    typedef enum logic [1:0] {IDLE, FILL, SWEEP} lb_state_e;

    typedef logic [BANK_BITS-1:0] bank_idx_t;
    typedef logic [$clog2(`LB_IMG_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(`LB_IMG_HEIGHT+1)-1:0] row_cnt_t;    // counts up to the full height

    // bank number offset from a base, wrapping over the five banks
    function automatic bank_idx_t bank_add(bank_idx_t base, bank_idx_t offset);
        logic [BANK_BITS:0] sum;
        sum = {1'b0, base} + {1'b0, offset};
        if (sum >= (BANK_BITS+1)'(`LB_NUM_BANKS)) begin
            sum = sum - (BANK_BITS+1)'(`LB_NUM_BANKS);
        end
        return sum[BANK_BITS-1:0];
    endfunction

endpackage

`default_nettype wire

/* hw/lb_row_bank.sv */
// Row memory bank
`default_nettype none

`include "lb_cfg.svh"

module lb_row_bank (
    input  wire logic                   clk,
    input  wire logic                   wr_en,
    input  wire lb_ctrl_pkg::col_addr_t wr_addr,
    input  wire lb_pixel_pkg::pixel_t   wr_data,
    input  wire logic                   rd_en,
    input  wire lb_ctrl_pkg::col_addr_t rd_addr,
    output lb_pixel_pkg::pixel_t        rd_data
);

    lb_pixel_pkg::pixel_t mem [`LB_IMG_WIDTH];    // one image row

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port, data shows up the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/lb_window_shifter.sv */
// Window column shifter
`default_nettype none

`include "lb_cfg.svh"

module lb_window_shifter (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   col_load,
    input  wire logic                   row_start,
    input  wire lb_ctrl_pkg::bank_idx_t base_bank,
    input  wire lb_pixel_pkg::pixel_t   bank_data [`LB_NUM_BANKS],
    output logic                        win_free,
    output logic                        win_valid,
    output lb_pixel_pkg::window_t       win_data,
    input  wire logic                   win_ready
);

    localparam int CNT_BITS = $clog2(`LB_WIN_SIZE + 1);

    lb_pixel_pkg::column_t new_col;
    lb_pixel_pkg::window_t shift_reg;
    logic [CNT_BITS-1:0]   col_cnt;
    logic [CNT_BITS-1:0]   load_cnt;
    logic                  copy_pending;

    //////////////////////////////////////////////////////////////////////
    // column assembly
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `LB_WIN_SIZE; k++) begin
            new_col[k] = bank_data[lb_ctrl_pkg::bank_add(base_bank,
                                                          lb_ctrl_pkg::bank_idx_t'(k))];
        end
    end

    always_ff @(posedge clk) begin
        if (col_load) begin
            shift_reg <= {new_col, shift_reg[`LB_WIN_SIZE-1:1]};    // newest column on the right
        end
    end

    // columns loaded in this row, held once a full window is present
    always_comb begin
        if (row_start) begin
            load_cnt = CNT_BITS'(1);
        end else if (col_cnt == CNT_BITS'(`LB_WIN_SIZE)) begin
            load_cnt = col_cnt;
        end else begin
            load_cnt = col_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output hold register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt      <= '0;
            copy_pending <= 1'b0;
            win_valid    <= 1'b0;
        end else begin
            if (col_load) begin
                col_cnt <= load_cnt;    // restarts at each row so windows stay within one row
            end
            copy_pending <= col_load && (load_cnt == CNT_BITS'(`LB_WIN_SIZE));
            if (copy_pending) begin
                win_valid <= 1'b1;
            end else if (win_ready) begin
                win_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (copy_pending) begin
            win_data <= shift_reg;
        end
    end

    // a read issued now lands in the hold register two cycles later
    assign win_free = !(win_valid && !win_ready) && !copy_pending && !col_load;

endmodule

`default_nettype wire

/* hw/lb_ctrl.sv */
// Line buffer controller
`default_nettype none

`include "lb_cfg.svh"

module lb_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pix_valid,
    output logic                        pix_ready,
    output logic [`LB_NUM_BANKS-1:0]    wr_en,
    output lb_ctrl_pkg::col_addr_t      wr_addr,
    output logic                        rd_en,
    output lb_ctrl_pkg::col_addr_t      rd_addr,
    output logic                        col_load,
    output logic                        row_start,
    output lb_ctrl_pkg::bank_idx_t      base_bank,
    input  wire logic                   win_free
);

    localparam lb_ctrl_pkg::col_addr_t LAST_COL  = lb_ctrl_pkg::col_addr_t'(`LB_IMG_WIDTH - 1);
    localparam lb_ctrl_pkg::row_cnt_t  LAST_FILL = lb_ctrl_pkg::row_cnt_t'(`LB_WIN_SIZE - 1);
    localparam lb_ctrl_pkg::row_cnt_t  ALL_ROWS  = lb_ctrl_pkg::row_cnt_t'(`LB_IMG_HEIGHT);

    lb_ctrl_pkg::lb_state_e state;
    lb_ctrl_pkg::col_addr_t wr_col;
    lb_ctrl_pkg::col_addr_t rd_col;
    lb_ctrl_pkg::row_cnt_t  wr_row;
    lb_ctrl_pkg::bank_idx_t wr_bank;
    logic                   in_sweep;
    logic                   pix_hs;
    logic                   wr_row_end;
    logic                   frame_in_done;
    logic                   spare_full;
    logic                   cols_done;
    logic                   sweep_end;
    logic                   last_sweep;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    assign in_sweep      = (state == lb_ctrl_pkg::SWEEP);
    assign frame_in_done = (wr_row == ALL_ROWS);

    // while sweeping, only the spare bank takes input and only one row of it
    assign pix_ready  = !in_sweep || (!spare_full && !frame_in_done);
    assign pix_hs     = pix_valid && pix_ready;
    assign wr_row_end = pix_hs && (wr_col == LAST_COL);

    always_comb begin
        if (in_sweep) begin
            wr_bank = lb_ctrl_pkg::bank_add(base_bank,
                                            lb_ctrl_pkg::bank_idx_t'(`LB_NUM_BANKS - 1));
        end else begin
            wr_bank = lb_ctrl_pkg::bank_add(base_bank, lb_ctrl_pkg::bank_idx_t'(wr_row));
        end
    end

    always_comb begin
        for (int i = 0; i < `LB_NUM_BANKS; i++) begin
            wr_en[i] = pix_hs && (wr_bank == lb_ctrl_pkg::bank_idx_t'(i));
        end
    end

    assign wr_addr = wr_col;

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    // one column in flight at most, and only when the shifter can take the result
    assign rd_en   = in_sweep && !cols_done && win_free && !col_load;
    assign rd_addr = rd_col;

    // all columns loaded and the next row is in place, or the frame has no more rows
    assign sweep_end  = in_sweep && cols_done && !col_load && (spare_full || frame_in_done);
    assign last_sweep = !spare_full;

    //////////////////////////////////////////////////////////////////////
    // state and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lb_ctrl_pkg::IDLE;
        end else begin
            case (state)
                lb_ctrl_pkg::IDLE: begin
                    if (pix_hs) begin
                        state <= lb_ctrl_pkg::FILL;    // first pixel of the first frame
                    end
                end
                lb_ctrl_pkg::FILL: begin
                    if (wr_row_end && (wr_row == LAST_FILL)) begin
                        state <= lb_ctrl_pkg::SWEEP;
                    end
                end
                lb_ctrl_pkg::SWEEP: begin
                    if (sweep_end && last_sweep) begin
                        state <= lb_ctrl_pkg::FILL;
                    end
                end
                default: begin
                    state <= lb_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_col     <= '0;
            wr_row     <= '0;
            spare_full <= 1'b0;
        end else begin
            if (pix_hs) begin
                wr_col <= (wr_col == LAST_COL) ? '0 : wr_col + 1'b1;
            end
            if (sweep_end && last_sweep) begin
                wr_row <= '0;    // next frame starts
            end else if (wr_row_end) begin
                wr_row <= wr_row + 1'b1;
            end
            if (sweep_end) begin
                spare_full <= 1'b0;
            end else if (in_sweep && wr_row_end) begin
                spare_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_col    <= '0;
            cols_done <= 1'b0;
            col_load  <= 1'b0;
            row_start <= 1'b0;
            base_bank <= '0;
        end else begin
            if (rd_en) begin
                rd_col <= (rd_col == LAST_COL) ? '0 : rd_col + 1'b1;
            end
            if (sweep_end) begin
                cols_done <= 1'b0;
            end else if (rd_en && (rd_col == LAST_COL)) begin
                cols_done <= 1'b1;
            end
            col_load  <= rd_en;    // bank data is valid one cycle after the read
            row_start <= rd_en && (rd_col == '0);
            if (sweep_end) begin
                base_bank <= lb_ctrl_pkg::bank_add(base_bank, lb_ctrl_pkg::bank_idx_t'(1));
            end
        end
    end

endmodule

`default_nettype wire

/* hw/line_buffer_top.sv */
// Bicubic line buffer
`default_nettype none

`include "lb_cfg.svh"

module line_buffer_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 pix_valid,
    output logic                      pix_ready,
    input  wire lb_pixel_pkg::pixel_t pix_data,
    output logic                      win_valid,
    input  wire logic                 win_ready,
    output lb_pixel_pkg::window_t     win_data
);

    wire logic [`LB_NUM_BANKS-1:0] wr_en;
    wire lb_ctrl_pkg::col_addr_t   wr_addr;
    wire lb_ctrl_pkg::col_addr_t   rd_addr;
    wire logic                     rd_en;
    wire logic                     col_load;
    wire logic                     row_start;
    wire logic                     win_free;
    wire lb_ctrl_pkg::bank_idx_t   base_bank;
    wire lb_pixel_pkg::pixel_t     bank_rd_data [`LB_NUM_BANKS];

    lb_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .col_load  (col_load),
        .row_start (row_start),
        .base_bank (base_bank),
        .win_free  (win_free)
    );

    //////////////////////////////////////////////////////////////////////
    // row memories, all written from the input stream
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `LB_NUM_BANKS; i++) begin : g_bank
        lb_row_bank u_bank (
            .clk     (clk),
            .wr_en   (wr_en[i]),
            .wr_addr (wr_addr),
            .wr_data (pix_data),
            .rd_en   (rd_en),
            .rd_addr (rd_addr),
            .rd_data (bank_rd_data[i])
        );
    end

    lb_window_shifter u_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .col_load  (col_load),
        .row_start (row_start),
        .base_bank (base_bank),
        .bank_data (bank_rd_data),
        .win_free  (win_free),
        .win_valid (win_valid),
        .win_data  (win_data),
        .win_ready (win_ready)
    );

endmodule

`default_nettype wire

/* tb/line_buffer_asserts.sv */
// Line buffer handshake checks
`default_nettype none

module line_buffer_asserts (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  pix_ready,
    input wire logic                  win_valid,
    input wire logic                  win_ready,
    input wire lb_pixel_pkg::window_t win_data
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // a window that is not taken stays in place
    hold_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        (win_valid && !win_ready) |=> (win_valid && $stable(win_data))
    ) else begin
        fail_count++;
        $error("window changed or dropped before it was taken");
    end

    reset_state: assert property (
        @(posedge clk) !rst_n |-> (!win_valid && pix_ready)
    ) else begin
        fail_count++;
        $error("win_valid or pix_ready wrong while in reset");
    end

    known_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        win_valid |-> !$isunknown(win_data)
    ) else begin
        fail_count++;
        $error("window data has unknown bits while valid");
    end

endmodule

`default_nettype wire

/* tb/line_buffer_tb.sv */
// Line buffer testbench
`default_nettype none

`include "lb_cfg.svh"

module line_buffer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMG_W         = `LB_IMG_WIDTH;
    localparam int IMG_H         = `LB_IMG_HEIGHT;
    localparam int WIN           = `LB_WIN_SIZE;
    localparam int PIX_PER_FRAME = IMG_W * IMG_H;
    localparam int WIN_PER_FRAME = (IMG_W - WIN + 1) * (IMG_H - WIN + 1);
    localparam int FRAMES_TOTAL  = 7;    // frames sent over all tests
    localparam int STALL_CYCLES  = 200;
    localparam int WATCHDOG_CYCLES =
        20 * (FRAMES_TOTAL * (PIX_PER_FRAME + WIN_PER_FRAME) + STALL_CYCLES) + 1000;

    logic                  clk;
    logic                  rst_n;
    logic                  pix_valid;
    logic                  pix_ready;
    lb_pixel_pkg::pixel_t  pix_data;
    logic                  win_valid;
    logic                  win_ready;
    lb_pixel_pkg::window_t win_data;

    lb_pixel_pkg::pixel_t  src_q [$];    // pixels still to be sent
    lb_pixel_pkg::window_t exp_q [$];    // windows still expected, in order
    int                    pix_sent;
    int                    win_got;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;

    line_buffer_top i_line_buffer_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_data  (win_data)
    );

    bind line_buffer_top line_buffer_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_ready (pix_ready),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_data  (win_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_window(int idx, lb_pixel_pkg::window_t got,
                                lb_pixel_pkg::window_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: window %0d is %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_pixel_count(string what, int got, int exp);
        if (got != exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, source and sink
    //////////////////////////////////////////////////////////////////////

    // random frame plus every window that lies fully inside it
    task automatic add_frame();
        lb_pixel_pkg::pixel_t  frame [$];
        lb_pixel_pkg::window_t w;
        for (int i = 0; i < PIX_PER_FRAME; i++) begin
            frame.push_back(lb_pixel_pkg::pixel_t'($urandom));
            src_q.push_back(frame[i]);
        end
        for (int r = WIN - 1; r < IMG_H; r++) begin
            for (int c = WIN - 1; c < IMG_W; c++) begin
                for (int j = 0; j < WIN; j++) begin
                    for (int k = 0; k < WIN; k++) begin
                        w[j][k] = frame[(r - WIN + 1 + k) * IMG_W + (c - WIN + 1 + j)];
                    end
                end
                exp_q.push_back(w);
            end
        end
    endtask

    task automatic drive_pixels(int valid_pct);
        logic want;
        while (src_q.size() > 0) begin
            @(posedge clk);
            want = ($urandom_range(99) < valid_pct);
            pix_valid <= want;
            pix_data  <= src_q[0];
            @(negedge clk);
            if (want && pix_ready) begin    // transfer at the coming edge
                void'(src_q.pop_front());
                pix_sent++;
            end
        end
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic collect_windows(int n, int ready_pct, int stall_at, int stall_len);
        logic rdy;
        logic stalled;
        int   pix_mark;
        stalled = 1'b0;
        while (win_got < n) begin
            @(posedge clk);
            if (!stalled && (stall_len > 0) && (win_got == stall_at)) begin
                stalled = 1'b1;
                win_ready <= 1'b0;
                pix_mark = pix_sent;
                repeat (stall_len) @(posedge clk);
                @(negedge clk);
                check_flag("pix_ready at end of stall", pix_ready, 1'b0);
                check_flag("win_valid at end of stall", win_valid, 1'b1);
                check_flag("input held to one row in stall", (pix_sent - pix_mark) <= IMG_W,
                           1'b1);
                @(posedge clk);
            end
            rdy = ($urandom_range(99) < ready_pct);
            win_ready <= rdy;
            @(negedge clk);
            if (rdy && win_valid) begin
                check_window(win_got, win_data, exp_q.pop_front());
                win_got++;
            end
        end
        @(posedge clk);
        win_ready <= 1'b0;
    endtask

    // keep the sink open so that any window beyond the expected ones is counted
    task automatic drain_windows();
        @(posedge clk);
        win_ready <= 1'b1;
        repeat (60) begin
            @(negedge clk);
            if (win_valid) begin
                win_got++;
            end
            @(posedge clk);
        end
        win_ready <= 1'b0;
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d, %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic run_frames(string name, int frames, int valid_pct, int ready_pct,
                              int stall_at, int stall_len);
        int errors_before;
        errors_before = errors;
        pix_sent      = 0;
        win_got       = 0;
        for (int f = 0; f < frames; f++) begin
            add_frame();
        end
        fork
            drive_pixels(valid_pct);
            collect_windows(exp_q.size(), ready_pct, stall_at, stall_len);
        join
        drain_windows();
        check_pixel_count("windows received", win_got, frames * WIN_PER_FRAME);
        report_test(name, errors_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int errors_before;
        errors_before = errors;
        @(negedge clk);
        check_flag("win_valid after reset", win_valid, 1'b0);
        check_flag("pix_ready after reset", pix_ready, 1'b1);
        report_test("state after reset", errors_before);
    endtask

    task automatic test_full_rate();
        run_frames("one frame at full rate", 1, 100, 100, -1, 0);
    endtask

    task automatic test_random_ready();
        run_frames("random win_ready", 1, 100, 50, -1, 0);
    endtask

    task automatic test_random_valid();
        run_frames("random pix_valid", 1, 50, 100, -1, 0);
    endtask

    task automatic test_two_frames();
        run_frames("two frames back to back", 2, 100, 100, -1, 0);
    endtask

    task automatic test_output_stall();
        run_frames("output stall in mid sweep", 2, 100, 100, 20, STALL_CYCLES);
    endtask

    initial begin
        void'($urandom(16614));
        rst_n        = 1'b0;
        pix_valid    = 1'b0;
        pix_data     = '0;
        win_ready    = 1'b0;
        pix_sent     = 0;
        win_got      = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_full_rate();
        test_random_ready();
        test_random_valid();
        test_two_frames();
        test_output_stall();
        errors += i_line_buffer_top.u_asserts.fail_count;
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/lb_pixel_pkg.sv
hw/lb_ctrl_pkg.sv
hw/lb_row_bank.sv
hw/lb_window_shifter.sv
hw/lb_ctrl.sv
hw/line_buffer_top.sv
tb/line_buffer_asserts.sv
tb/line_buffer_tb.sv

/* Bender.yml */
package:
  name: line_buffer

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lb_pixel_pkg.sv
      - hw/lb_ctrl_pkg.sv
      - hw/lb_row_bank.sv
      - hw/lb_window_shifter.sv
      - hw/lb_ctrl.sv
      - hw/line_buffer_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/line_buffer_asserts.sv
      - tb/line_buffer_tb.sv
